// File: logic/surfturf_pkg.sv
package surfturf_pkg;

    // widths that carry a meaning
    typedef logic [31:0] cmd_word_t;
    typedef logic [1:0]  runcmd_t;
    typedef logic [14:0] trig_t;
    typedef logic [7:0]  fw_byte_t;
    typedef logic [6:0]  surf_mask_t;

    // number of downstream digitizer links
    localparam int NUM_SURFS = 7;

    // command field positions, bits 6:1 are reserved and pass through
    localparam int CMD_RUN_LSB  = 30;
    localparam int CMD_TRIG_LSB = 15;
    localparam int CMD_FW_LSB   = 7;
    localparam int CMD_PPS_BIT  = 0;

    // side-channel selector carried on tuser
    typedef enum logic [1:0] {
        SEL_RUNCMD  = 2'd0,
        SEL_FW      = 2'd1,
        SEL_TRIG_LO = 2'd2,
        SEL_TRIG_HI = 2'd3
    } mode1_sel_t;

    // lock machine of the alignment stage
    typedef enum logic [1:0] {
        ST_HUNT   = 2'd0,
        ST_COUNT  = 2'd1,
        ST_LOCKED = 2'd2
    } align_state_t;

    // register word addresses
    localparam logic [3:0] REG_CONTROL      = 4'd0;
    localparam logic [3:0] REG_STATUS       = 4'd1;
    localparam logic [3:0] REG_CMD_COUNT    = 4'd2;
    localparam logic [3:0] REG_SPLICE_COUNT = 4'd3;

endpackage

// File: logic/cmd_stage_if.sv
interface cmd_stage_if;
    import surfturf_pkg::*;

    // command word, valid for one cycle per command
    cmd_word_t cmd;
    logic      valid;
    // lock level of the upstream aligner
    logic      locked;
    // forwarded sync pulse
    logic      sync;

    // no back-pressure, the upstream stage drives everything
    modport src (
        output cmd,
        output valid,
        output locked,
        output sync
    );

    modport dst (
        input cmd,
        input valid,
        input locked,
        input sync
    );

endinterface

// File: logic/turf_cmd_align.sv
module turf_cmd_align #(
    parameter surfturf_pkg::cmd_word_t TRAIN_SEQUENCE = 32'hA55A6996,
    parameter int LOCK_COUNT = 4
) (
    input  logic                    sysclk_i,
    input  logic                    rst_n_i,
    input  surfturf_pkg::cmd_word_t rx_word_i,
    input  logic                    rx_valid_i,
    input  logic                    sync_i,
    input  logic                    relock_i,
    cmd_stage_if.src                out_o
);
    import surfturf_pkg::*;

    localparam int CNT_W = $clog2(LOCK_COUNT + 1);

    align_state_t     state_q;
    logic [CNT_W-1:0] count_q;
    logic             is_train;

    assign is_train = (rx_word_i == TRAIN_SEQUENCE);

    // lock level comes straight off the state register
    assign out_o.locked = (state_q == ST_LOCKED);

    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= ST_HUNT;
            count_q     <= '0;
            out_o.valid <= 1'b0;
            out_o.sync  <= 1'b0;
        end else begin
            out_o.sync  <= sync_i;
            out_o.valid <= 1'b0;
            if (relock_i) begin
                state_q <= ST_HUNT;
                count_q <= '0;
            end else if (rx_valid_i) begin
                case (state_q)
                    ST_HUNT, ST_COUNT: begin
                        if (!is_train) begin
                            // run of training words broken
                            state_q <= ST_HUNT;
                            count_q <= '0;
                        end else if (count_q == CNT_W'(LOCK_COUNT - 1)) begin
                            state_q <= ST_LOCKED;
                            count_q <= '0;
                        end else begin
                            state_q <= ST_COUNT;
                            count_q <= count_q + 1'b1;
                        end
                    end
                    ST_LOCKED: begin
                        // training words are dropped once locked
                        out_o.valid <= !is_train;
                    end
                    default: begin
                        state_q <= ST_HUNT;
                        count_q <= '0;
                    end
                endcase
            end
        end
    end

    // command word register
    always_ff @(posedge sysclk_i) begin
        if (rx_valid_i) begin
            out_o.cmd <= rx_word_i;
        end
    end

    // a command never leaves without lock, relock included
    assert property (@(posedge sysclk_i) disable iff (!rst_n_i)
        out_o.valid |-> out_o.locked);

endmodule

// File: logic/turfio_cmd_splice.sv
module turfio_cmd_splice (
    input  logic                     sysclk_i,
    input  logic                     rst_n_i,
    cmd_stage_if.dst                 in_i,
    cmd_stage_if.src                 out_o,
    input  surfturf_pkg::fw_byte_t   mode1_tdata_i,
    input  surfturf_pkg::mode1_sel_t mode1_tuser_i,
    input  logic                     mode1_tvalid_i,
    input  logic                     tfio_pps_i,
    input  logic                     use_tfio_pps_i,
    output logic                     splice_o
);
    import surfturf_pkg::*;

    // pending local fields
    runcmd_t   run_q;
    fw_byte_t  fw_q;
    logic [7:0] trig_lo_q;
    logic [6:0] trig_hi_q;
    logic      run_armed_q;
    logic      fw_armed_q;
    logic      trig_armed_q;
    logic      pps_flag_q;
    cmd_word_t spliced;
    logic      any_field;

    always_comb begin
        spliced = in_i.cmd;
        if (run_armed_q) begin
            spliced[CMD_RUN_LSB +: $bits(runcmd_t)] = run_q;
        end
        if (trig_armed_q) begin
            spliced[CMD_TRIG_LSB +: $bits(trig_t)] = trig_t'({trig_hi_q, trig_lo_q});
        end
        if (fw_armed_q) begin
            spliced[CMD_FW_LSB +: $bits(fw_byte_t)] = fw_q;
        end
        // local pps owns bit 0 only when selected
        if (use_tfio_pps_i) begin
            spliced[CMD_PPS_BIT] = pps_flag_q;
        end
    end

    // pps alone does not count as a splice
    assign any_field = run_armed_q | fw_armed_q | trig_armed_q;

    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            run_armed_q  <= 1'b0;
            fw_armed_q   <= 1'b0;
            trig_armed_q <= 1'b0;
            pps_flag_q   <= 1'b0;
            out_o.valid  <= 1'b0;
            out_o.locked <= 1'b0;
            out_o.sync   <= 1'b0;
            splice_o     <= 1'b0;
        end else begin
            out_o.valid  <= in_i.valid;
            out_o.locked <= in_i.locked;
            out_o.sync   <= in_i.sync;
            splice_o     <= in_i.valid & any_field;
            // a beat in the same cycle as a command stays pending for the next one
            if (in_i.valid) begin
                run_armed_q  <= 1'b0;
                fw_armed_q   <= 1'b0;
                trig_armed_q <= 1'b0;
            end
            if (mode1_tvalid_i) begin
                case (mode1_tuser_i)
                    SEL_RUNCMD:  run_armed_q  <= 1'b1;
                    SEL_FW:      fw_armed_q   <= 1'b1;
                    SEL_TRIG_HI: trig_armed_q <= 1'b1;
                    default: begin
                        // low trigger byte waits for the high byte
                    end
                endcase
            end
            if (!use_tfio_pps_i) begin
                pps_flag_q <= 1'b0;
            end else if (tfio_pps_i) begin
                pps_flag_q <= 1'b1;
            end else if (in_i.valid) begin
                pps_flag_q <= 1'b0;
            end
        end
    end

    // field payloads and the output word
    always_ff @(posedge sysclk_i) begin
        out_o.cmd <= spliced;
        if (mode1_tvalid_i) begin
            case (mode1_tuser_i)
                SEL_RUNCMD:  run_q     <= mode1_tdata_i[1:0];
                SEL_FW:      fw_q      <= mode1_tdata_i;
                SEL_TRIG_LO: trig_lo_q <= mode1_tdata_i;
                SEL_TRIG_HI: trig_hi_q <= mode1_tdata_i[6:0];
            endcase
        end
    end

    assert property (@(posedge sysclk_i) disable iff (!rst_n_i)
        mode1_tvalid_i |-> !$isunknown(mode1_tuser_i));

endmodule

// File: logic/surf_cmd_fanout.sv
module surf_cmd_fanout (
    input  logic                     sysclk_i,
    input  logic                     rst_n_i,
    cmd_stage_if.dst                 in_i,
    input  surfturf_pkg::surf_mask_t surf_enable_i,
    output surfturf_pkg::cmd_word_t  surf_command_o,
    output surfturf_pkg::surf_mask_t surf_cmd_valid_o,
    output logic                     surf_sync_o
);
    import surfturf_pkg::*;

    surf_mask_t link_valid;

    // one strobe per link, gated by the enable mask
    assign link_valid = {NUM_SURFS{in_i.valid}} & surf_enable_i;

    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            surf_cmd_valid_o <= '0;
            surf_sync_o      <= 1'b0;
        end else begin
            surf_cmd_valid_o <= link_valid;
            surf_sync_o      <= in_i.sync;
        end
    end

    // all links share the same command word
    always_ff @(posedge sysclk_i) begin
        surf_command_o <= in_i.cmd;
    end

    // lock travels one stage behind the aligner, strobes must still respect it
    assert property (@(posedge sysclk_i) disable iff (!rst_n_i)
        !in_i.locked |=> (surf_cmd_valid_o == '0));

endmodule

// File: logic/surfturf_regs.sv
module surfturf_regs (
    input  logic                     sysclk_i,
    input  logic                     rst_n_i,
    input  logic                     wb_cyc_i,
    input  logic                     wb_stb_i,
    input  logic                     wb_we_i,
    input  logic [3:0]               wb_adr_i,
    input  logic [31:0]              wb_dat_i,
    output logic [31:0]              wb_dat_o,
    output logic                     wb_ack_o,
    input  logic                     locked_i,
    input  logic                     cmd_valid_i,
    input  logic                     splice_i,
    output surfturf_pkg::surf_mask_t surf_enable_o,
    output logic                     use_tfio_pps_o,
    output logic                     relock_o
);
    import surfturf_pkg::*;

    logic        req;
    logic        ctrl_wr;
    logic [31:0] cmd_count_q;
    logic [31:0] splice_count_q;
    logic [31:0] rd_data;

    // a new request is one that has not been acked yet
    assign req     = wb_cyc_i & wb_stb_i & ~wb_ack_o;
    assign ctrl_wr = req & wb_we_i & (wb_adr_i == REG_CONTROL);

    always_comb begin
        case (wb_adr_i)
            REG_CONTROL:      rd_data = {24'd0, use_tfio_pps_o, surf_enable_o};
            REG_STATUS:       rd_data = {31'd0, locked_i};
            REG_CMD_COUNT:    rd_data = cmd_count_q;
            REG_SPLICE_COUNT: rd_data = splice_count_q;
            default:          rd_data = 32'd0;
        endcase
    end

    // ack and control fields
    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_ack_o       <= 1'b0;
            surf_enable_o  <= '0;
            use_tfio_pps_o <= 1'b0;
            relock_o       <= 1'b0;
        end else begin
            wb_ack_o <= req;
            // relock is a strobe that never reads back
            relock_o <= ctrl_wr & wb_dat_i[8];
            if (ctrl_wr) begin
                surf_enable_o  <= wb_dat_i[6:0];
                use_tfio_pps_o <= wb_dat_i[7];
            end
        end
    end

    // read data is captured with the request and held through ack
    always_ff @(posedge sysclk_i) begin
        if (req) begin
            wb_dat_o <= rd_data;
        end
    end

    // counters clear on relock
    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cmd_count_q    <= '0;
            splice_count_q <= '0;
        end else if (relock_o) begin
            cmd_count_q    <= '0;
            splice_count_q <= '0;
        end else begin
            if (cmd_valid_i) begin
                cmd_count_q <= cmd_count_q + 32'd1;
            end
            if (splice_i) begin
                splice_count_q <= splice_count_q + 32'd1;
            end
        end
    end

    // a held strobe must not produce back-to-back acks
    assert property (@(posedge sysclk_i) disable iff (!rst_n_i)
        wb_ack_o |=> !wb_ack_o);

endmodule

// File: logic/surfturf_top.sv
module surfturf_top #(
    parameter surfturf_pkg::cmd_word_t TRAIN_SEQUENCE = 32'hA55A6996,
    parameter int LOCK_COUNT = 4
) (
    input  logic                     sysclk_i,
    input  logic                     rst_n_i,
    // upstream command stream
    input  surfturf_pkg::cmd_word_t  rx_word_i,
    input  logic                     rx_valid_i,
    input  logic                     sync_i,
    // side channel and local pps
    input  surfturf_pkg::fw_byte_t   mode1_tdata_i,
    input  surfturf_pkg::mode1_sel_t mode1_tuser_i,
    input  logic                     mode1_tvalid_i,
    input  logic                     tfio_pps_i,
    // register bus
    input  logic                     wb_cyc_i,
    input  logic                     wb_stb_i,
    input  logic                     wb_we_i,
    input  logic [3:0]               wb_adr_i,
    input  logic [31:0]              wb_dat_i,
    output logic [31:0]              wb_dat_o,
    output logic                     wb_ack_o,
    // downstream links
    output logic                     command_locked_o,
    output surfturf_pkg::cmd_word_t  surf_command_o,
    output surfturf_pkg::surf_mask_t surf_cmd_valid_o,
    output logic                     surf_sync_o
);
    import surfturf_pkg::*;

    cmd_stage_if align_if ();
    cmd_stage_if splice_if ();

    surf_mask_t surf_enable;
    logic       use_tfio_pps;
    logic       relock;
    logic       splice;

    assign command_locked_o = align_if.locked;

    turf_cmd_align #(
        .TRAIN_SEQUENCE(TRAIN_SEQUENCE),
        .LOCK_COUNT    (LOCK_COUNT)
    ) u_align (
        .sysclk_i  (sysclk_i),
        .rst_n_i   (rst_n_i),
        .rx_word_i (rx_word_i),
        .rx_valid_i(rx_valid_i),
        .sync_i    (sync_i),
        .relock_i  (relock),
        .out_o     (align_if.src)
    );

    turfio_cmd_splice u_splice (
        .sysclk_i      (sysclk_i),
        .rst_n_i       (rst_n_i),
        .in_i          (align_if.dst),
        .out_o         (splice_if.src),
        .mode1_tdata_i (mode1_tdata_i),
        .mode1_tuser_i (mode1_tuser_i),
        .mode1_tvalid_i(mode1_tvalid_i),
        .tfio_pps_i    (tfio_pps_i),
        .use_tfio_pps_i(use_tfio_pps),
        .splice_o      (splice)
    );

    surf_cmd_fanout u_fanout (
        .sysclk_i        (sysclk_i),
        .rst_n_i         (rst_n_i),
        .in_i            (splice_if.dst),
        .surf_enable_i   (surf_enable),
        .surf_command_o  (surf_command_o),
        .surf_cmd_valid_o(surf_cmd_valid_o),
        .surf_sync_o     (surf_sync_o)
    );

    // command counter watches commands leaving the aligner
    surfturf_regs u_regs (
        .sysclk_i      (sysclk_i),
        .rst_n_i       (rst_n_i),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_we_i       (wb_we_i),
        .wb_adr_i      (wb_adr_i),
        .wb_dat_i      (wb_dat_i),
        .wb_dat_o      (wb_dat_o),
        .wb_ack_o      (wb_ack_o),
        .locked_i      (align_if.locked),
        .cmd_valid_i   (align_if.valid),
        .splice_i      (splice),
        .surf_enable_o (surf_enable),
        .use_tfio_pps_o(use_tfio_pps),
        .relock_o      (relock)
    );

endmodule

// File: tests/surfturf_tb.sv
module surfturf_tb;
    import surfturf_pkg::*;

    localparam int        CLK_PERIOD = 4;
    localparam int        LOCK_COUNT = 4;
    localparam cmd_word_t TRAIN      = 32'hA55A6996;

    typedef enum logic [2:0] {
        OP_WRITE, OP_READ, OP_TRAIN, OP_CMD, OP_BEAT, OP_PPS, OP_SYNC, OP_DONE
    } op_t;

    // expected value of train and command rows is the lock level after them
    typedef struct {
        op_t         op;
        logic [3:0]  addr;
        logic [31:0] data;
        logic [31:0] expected;
    } row_t;

    logic        sysclk_i;
    logic        rst_n_i;
    cmd_word_t   rx_word_i;
    logic        rx_valid_i;
    logic        sync_i;
    fw_byte_t    mode1_tdata_i;
    mode1_sel_t  mode1_tuser_i;
    logic        mode1_tvalid_i;
    logic        tfio_pps_i;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [3:0]  wb_adr_i;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack_o;
    logic        command_locked_o;
    cmd_word_t   surf_command_o;
    surf_mask_t  surf_cmd_valid_o;
    logic        surf_sync_o;

    row_t        rows[$];
    int          due_q[$];
    int          sync_due_q[$];
    cmd_word_t   cmd_q[$];
    surf_mask_t  mask_q[$];
    int          cycle_count;
    int          check_count;
    int          error_count;
    int          test_count;
    logic [31:0] lfsr;

    // reference model state
    logic        model_locked;
    int          train_run;
    surf_mask_t  model_mask;
    logic        model_use_pps;
    logic        model_pps;
    logic [1:0]  model_run;
    logic [7:0]  model_fw;
    logic [7:0]  model_trig_lo;
    logic [6:0]  model_trig_hi;
    logic        run_armed;
    logic        fw_armed;
    logic        trig_armed;
    int          model_cmds;
    int          model_splices;

    surfturf_top #(
        .TRAIN_SEQUENCE(TRAIN),
        .LOCK_COUNT    (LOCK_COUNT)
    ) u_dut (
        .sysclk_i        (sysclk_i),
        .rst_n_i         (rst_n_i),
        .rx_word_i       (rx_word_i),
        .rx_valid_i      (rx_valid_i),
        .sync_i          (sync_i),
        .mode1_tdata_i   (mode1_tdata_i),
        .mode1_tuser_i   (mode1_tuser_i),
        .mode1_tvalid_i  (mode1_tvalid_i),
        .tfio_pps_i      (tfio_pps_i),
        .wb_cyc_i        (wb_cyc_i),
        .wb_stb_i        (wb_stb_i),
        .wb_we_i         (wb_we_i),
        .wb_adr_i        (wb_adr_i),
        .wb_dat_i        (wb_dat_i),
        .wb_dat_o        (wb_dat_o),
        .wb_ack_o        (wb_ack_o),
        .command_locked_o(command_locked_o),
        .surf_command_o  (surf_command_o),
        .surf_cmd_valid_o(surf_cmd_valid_o),
        .surf_sync_o     (surf_sync_o)
    );

    always #(CLK_PERIOD / 2) sysclk_i = ~sysclk_i;

    always @(posedge sysclk_i) begin
        cycle_count <= cycle_count + 1;
    end

    // galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic cmd_word_t random_word();
        cmd_word_t w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            w = {w[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return w;
    endfunction

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s, got %h, expected %h",
                     $time, msg, actual, expected);
        end
    endtask

    task automatic add_row(input op_t op, input logic [3:0] addr, input logic [31:0] data,
                           input logic [31:0] expected);
        rows.push_back('{op, addr, data, expected});
    endtask

    task automatic step();
        @(posedge sysclk_i);
        #1;
    endtask

    // pipeline drains before each access so counters and control are settled
    task automatic bus_access(input logic we, input logic [3:0] addr, input logic [31:0] data,
                              output logic [31:0] rdata);
        int waited;
        waited = 0;
        repeat (3) step();
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = addr;
        wb_dat_i = data;
        step();
        while (!wb_ack_o && waited < 8) begin
            step();
            waited++;
        end
        if (!wb_ack_o) begin
            error_count++;
            $display("register bus gave no ack for address %0d", addr);
        end
        rdata    = wb_dat_o;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        step();
    endtask

    // applies the splice rules and queues the word expected on the links
    task automatic model_issue(input cmd_word_t word);
        cmd_word_t exp_word;
        exp_word = word;
        if (run_armed) begin
            exp_word[31:30] = model_run;
        end
        if (trig_armed) begin
            exp_word[29:15] = {model_trig_hi, model_trig_lo};
        end
        if (fw_armed) begin
            exp_word[14:7] = model_fw;
        end
        if (model_use_pps) begin
            exp_word[0] = model_pps;
        end
        model_cmds++;
        if (run_armed || fw_armed || trig_armed) begin
            model_splices++;
        end
        run_armed  = 1'b0;
        fw_armed   = 1'b0;
        trig_armed = 1'b0;
        model_pps  = 1'b0;
        due_q.push_back(cycle_count + 3);
        cmd_q.push_back(exp_word);
        mask_q.push_back(model_mask);
    endtask

    task automatic send_word(input cmd_word_t word);
        rx_word_i  = word;
        rx_valid_i = 1'b1;
        if (model_locked && word != TRAIN) begin
            model_issue(word);
        end else if (!model_locked && word == TRAIN) begin
            train_run++;
            if (train_run == LOCK_COUNT) begin
                model_locked = 1'b1;
                train_run    = 0;
            end
        end else if (!model_locked) begin
            train_run = 0;
        end
        step();
        rx_valid_i = 1'b0;
    endtask

    task automatic send_beat(input mode1_sel_t sel, input fw_byte_t data);
        mode1_tvalid_i = 1'b1;
        mode1_tuser_i  = sel;
        mode1_tdata_i  = data;
        case (sel)
            SEL_RUNCMD: begin
                model_run = data[1:0];
                run_armed = 1'b1;
            end
            SEL_FW: begin
                model_fw = data;
                fw_armed = 1'b1;
            end
            SEL_TRIG_LO: model_trig_lo = data;
            default: begin
                model_trig_hi = data[6:0];
                trig_armed    = 1'b1;
            end
        endcase
        step();
        mode1_tvalid_i = 1'b0;
    endtask

    task automatic send_pps();
        tfio_pps_i = 1'b1;
        if (model_use_pps) begin
            model_pps = 1'b1;
        end
        step();
        tfio_pps_i = 1'b0;
    endtask

    // sync reaches the links three cycles later whatever the lock state
    task automatic send_sync();
        sync_i = 1'b1;
        sync_due_q.push_back(cycle_count + 3);
        step();
        sync_i = 1'b0;
    endtask

    task automatic model_control(input logic [31:0] data);
        model_mask    = data[6:0];
        model_use_pps = data[7];
        if (!data[7]) begin
            model_pps = 1'b0;
        end
        if (data[8]) begin
            model_locked  = 1'b0;
            train_run     = 0;
            model_cmds    = 0;
            model_splices = 0;
        end
    endtask

    function automatic logic [31:0] read_expect(input row_t r);
        if (r.addr == REG_CMD_COUNT) begin
            return 32'(model_cmds);
        end
        if (r.addr == REG_SPLICE_COUNT) begin
            return 32'(model_splices);
        end
        return r.expected;
    endfunction

    // compares the links against the queued model output
    always @(negedge sysclk_i) begin : link_monitor
        surf_mask_t exp_mask;
        cmd_word_t  exp_cmd;
        if (rst_n_i) begin
            if (due_q.size() > 0 && due_q[0] == cycle_count) begin
                exp_mask = mask_q.pop_front();
                exp_cmd  = cmd_q.pop_front();
                void'(due_q.pop_front());
                check(32'(surf_cmd_valid_o), 32'(exp_mask), "link valid strobes");
                if (exp_mask != '0) begin
                    check(surf_command_o, exp_cmd, "command word on the links");
                end
            end else begin
                check(32'(surf_cmd_valid_o), 32'd0, "no command expected on the links");
            end
            if (sync_due_q.size() > 0 && sync_due_q[0] == cycle_count) begin
                void'(sync_due_q.pop_front());
                check(32'(surf_sync_o), 32'd1, "sync forwarded to the links");
            end else begin
                check(32'(surf_sync_o), 32'd0, "no sync expected on the links");
            end
        end
    end

    initial begin
        #1;
        #((rows.size() * 20 + 8) * CLK_PERIOD);
        $display("timeout, the run did not finish in the expected time");
        $display("tests failed");
        $finish;
    end

    initial begin : main
        logic [31:0] rdata;
        cmd_word_t   word;
        int          errors_before;
        sysclk_i       = 1'b0;
        rst_n_i        = 1'b0;
        rx_word_i      = '0;
        rx_valid_i     = 1'b0;
        sync_i         = 1'b0;
        mode1_tdata_i  = '0;
        mode1_tuser_i  = SEL_RUNCMD;
        mode1_tvalid_i = 1'b0;
        tfio_pps_i     = 1'b0;
        wb_cyc_i       = 1'b0;
        wb_stb_i       = 1'b0;
        wb_we_i        = 1'b0;
        wb_adr_i       = '0;
        wb_dat_i       = '0;
        lfsr           = 32'hf936;
        check_count    = 0;
        error_count    = 0;
        test_count     = 0;
        errors_before  = 0;
        model_locked   = 1'b0;
        train_run      = 0;
        model_mask     = '0;
        model_use_pps  = 1'b0;
        model_pps      = 1'b0;
        run_armed      = 1'b0;
        fw_armed       = 1'b0;
        trig_armed     = 1'b0;
        model_cmds     = 0;
        model_splices  = 0;

        // lock needs four training words in a row
        add_row(OP_TRAIN, 4'd0, 32'd0, 32'd0);
        add_row(OP_TRAIN, 4'd0, 32'd0, 32'd0);
        add_row(OP_TRAIN, 4'd0, 32'd0, 32'd0);
        add_row(OP_CMD,   4'd0, 32'd0, 32'd0);
        add_row(OP_TRAIN, 4'd0, 32'd0, 32'd0);
        add_row(OP_TRAIN, 4'd0, 32'd0, 32'd0);
        add_row(OP_TRAIN, 4'd0, 32'd0, 32'd0);
        add_row(OP_TRAIN, 4'd0, 32'd0, 32'd1);
        add_row(OP_READ,  REG_STATUS, 32'd0, 32'd1);
        add_row(OP_DONE,  4'd1, 32'd0, 32'd0);
        // commands pass unchanged and training words are dropped
        add_row(OP_WRITE, REG_CONTROL, 32'h07f, 32'd0);
        add_row(OP_CMD,   4'd0, 32'd0, 32'd1);
        add_row(OP_CMD,   4'd0, 32'd0, 32'd1);
        add_row(OP_TRAIN, 4'd0, 32'd0, 32'd1);
        add_row(OP_SYNC,  4'd0, 32'd0, 32'd0);
        add_row(OP_CMD,   4'd0, 32'd0, 32'd1);
        add_row(OP_DONE,  4'd2, 32'd0, 32'd0);
        // side-channel fields land in the next command only
        add_row(OP_BEAT,  4'(SEL_RUNCMD), 32'h02, 32'd0);
        add_row(OP_CMD,   4'd0, 32'hc0000000, 32'd1);
        add_row(OP_CMD,   4'd0, 32'd0, 32'd1);
        add_row(OP_BEAT,  4'(SEL_FW), 32'ha5, 32'd0);
        add_row(OP_BEAT,  4'(SEL_TRIG_LO), 32'h3c, 32'd0);
        add_row(OP_BEAT,  4'(SEL_TRIG_HI), 32'h5b, 32'd0);
        add_row(OP_CMD,   4'd0, 32'h3fffff80, 32'd1);
        add_row(OP_READ,  REG_SPLICE_COUNT, 32'd0, 32'd0);
        add_row(OP_READ,  REG_CMD_COUNT, 32'd0, 32'd0);
        add_row(OP_DONE,  4'd3, 32'd0, 32'd0);
        // enable mask gates the links
        add_row(OP_WRITE, REG_CONTROL, 32'h055, 32'd0);
        add_row(OP_CMD,   4'd0, 32'd0, 32'd1);
        add_row(OP_CMD,   4'd0, 32'd0, 32'd1);
        add_row(OP_WRITE, REG_CONTROL, 32'h02a, 32'd0);
        add_row(OP_CMD,   4'd0, 32'd0, 32'd1);
        add_row(OP_DONE,  4'd4, 32'd0, 32'd0);
        // local pps owns bit 0 only when selected
        add_row(OP_WRITE, REG_CONTROL, 32'h0ff, 32'd0);
        add_row(OP_PPS,   4'd0, 32'd0, 32'd0);
        add_row(OP_CMD,   4'd0, 32'd1, 32'd1);
        add_row(OP_CMD,   4'd1, 32'd1, 32'd1);
        add_row(OP_WRITE, REG_CONTROL, 32'h07f, 32'd0);
        add_row(OP_CMD,   4'd1, 32'd1, 32'd1);
        add_row(OP_DONE,  4'd5, 32'd0, 32'd0);
        // relock drops lock and clears the counters
        add_row(OP_WRITE, REG_CONTROL, 32'h17f, 32'd0);
        add_row(OP_READ,  REG_STATUS, 32'd0, 32'd0);
        add_row(OP_READ,  REG_CMD_COUNT, 32'd0, 32'd0);
        add_row(OP_READ,  REG_SPLICE_COUNT, 32'd0, 32'd0);
        add_row(OP_CMD,   4'd0, 32'd0, 32'd0);
        add_row(OP_TRAIN, 4'd0, 32'd0, 32'd0);
        add_row(OP_TRAIN, 4'd0, 32'd0, 32'd0);
        add_row(OP_TRAIN, 4'd0, 32'd0, 32'd0);
        add_row(OP_TRAIN, 4'd0, 32'd0, 32'd1);
        add_row(OP_CMD,   4'd0, 32'd0, 32'd1);
        add_row(OP_DONE,  4'd6, 32'd0, 32'd0);

        repeat (8) @(posedge sysclk_i);
        #1;
        rst_n_i = 1'b1;
        check(32'(command_locked_o), 32'd0, "lock low after reset");
        check(32'(surf_cmd_valid_o), 32'd0, "link strobes low after reset");

        foreach (rows[i]) begin
            case (rows[i].op)
                OP_WRITE: begin
                    bus_access(1'b1, rows[i].addr, rows[i].data, rdata);
                    model_control(rows[i].data);
                end
                OP_READ: begin
                    bus_access(1'b0, rows[i].addr, 32'd0, rdata);
                    check(rdata, read_expect(rows[i]), "register read");
                end
                OP_TRAIN: begin
                    send_word(TRAIN);
                    check(32'(command_locked_o), rows[i].expected, "lock after training word");
                end
                OP_CMD: begin
                    word = random_word();
                    // payload bits picked by the row data take the value of addr bit 0
                    word = (word & ~rows[i].data) | (rows[i].data & {32{rows[i].addr[0]}});
                    if (word == TRAIN) begin
                        word[1] = ~word[1];
                    end
                    send_word(word);
                    check(32'(command_locked_o), rows[i].expected, "lock after command");
                end
                OP_BEAT: send_beat(mode1_sel_t'(rows[i].addr[1:0]), rows[i].data[7:0]);
                OP_PPS: send_pps();
                OP_SYNC: send_sync();
                default: begin
                    repeat (4) step();
                    test_count++;
                    $display("test %0d finished with %0d mismatches",
                             rows[i].addr, error_count - errors_before);
                    errors_before = error_count;
                end
            endcase
        end

        $display("%0d tests, %0d checks, %0d mismatches", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: compile.f
logic/surfturf_pkg.sv
logic/cmd_stage_if.sv
logic/turf_cmd_align.sv
logic/turfio_cmd_splice.sv
logic/surf_cmd_fanout.sv
logic/surfturf_regs.sv
logic/surfturf_top.sv
tests/surfturf_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= surfturf_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "all tests passed"

clean:
	rm -rf $(OBJ_DIR)
